// File: hdl/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

    // number of hardware sprites and the width of an index into them
    localparam int NUM_SPRITES = 8;
    localparam int SPRITE_ID_W = 3;

    // beam and sprite x positions share one width
    localparam int XPOS_W = 9;

    // one sprite line is three bytes of bitmap data
    localparam int SPRITE_DATA_W = 24;

    // a single sprite pixel, 0 means transparent
    typedef logic [1:0] sprite_pix_t;

    // one bit per sprite, used for mmc, pri and the collision registers
    typedef logic [NUM_SPRITES-1:0] sprite_mask_t;

    // current pixel of every sprite, index 0 is sprite 0
    typedef sprite_pix_t [NUM_SPRITES-1:0] sprite_pix_vec_t;

    // static per-sprite settings as seen by the shifter
    typedef struct packed {
        logic [XPOS_W-1:0] xpos;
        logic              display;
        logic              xexp;
        logic              mc;
    } sprite_cfg_t;

    typedef sprite_cfg_t [NUM_SPRITES-1:0] sprite_cfg_vec_t;

    // settings that must travel alongside a pixel through the delay pipeline
    // active_sprite holds a valid flag in its top bit and the sprite index below
    typedef struct packed {
        sprite_mask_t         mmc;
        sprite_mask_t         pri;
        logic [SPRITE_ID_W:0] active_sprite;
    } sprite_attr_t;

    // one line of sprite data aimed at a single sprite
    typedef struct packed {
        logic [SPRITE_ID_W-1:0]   id;
        logic [SPRITE_DATA_W-1:0] data;
    } sprite_load_t;

endpackage : sprite_pkg

`default_nettype wire

// File: hdl/sprite_shifter.sv
`timescale 1ns/1ps
`default_nettype none

// per-sprite pixel shifter
// the data register is shifted out msb first once the beam reaches the sprite x
module sprite_shifter
    import sprite_pkg::*;
#(
    parameter int SPRITE_ID = 0
) (
    input  wire          clk_dot4x,
    input  wire          rst,
    input  wire          pixel_tick_i,
    input  wire [XPOS_W-1:0] xpos_i,
    input  wire sprite_cfg_t  cfg_i,
    input  wire          load_valid_i,
    input  wire sprite_load_t load_i,
    output sprite_pix_t  pixel_o
);

    localparam logic [SPRITE_ID_W-1:0] MY_ID = SPRITE_ID_W'(SPRITE_ID);
    localparam int DATA_MSB = SPRITE_DATA_W - 1;
    localparam int CNT_W = $clog2(SPRITE_DATA_W);
    // the activating tick already consumes the first bit
    localparam logic [CNT_W-1:0] FIRST_LEFT = CNT_W'(SPRITE_DATA_W - 1);

    logic [SPRITE_DATA_W-1:0] data_q;
    logic                     active_q;
    logic                     xe_ff_q;
    logic                     mc_ff_q;
    logic [CNT_W-1:0]         steps_left_q;

    logic x_match;
    logic start;
    logic step;
    logic finish;
    logic mc_take;
    logic load_hit;

    // beam x match only counts while the sprite is enabled for this line
    assign x_match = cfg_i.display && (cfg_i.xpos == xpos_i);
    assign start   = pixel_tick_i && !active_q && x_match;

    // xe_ff high means this tick advances to the next data bit
    // with expansion off it stays high and every tick advances
    assign step   = pixel_tick_i && active_q && xe_ff_q && (steps_left_q != '0);
    assign finish = pixel_tick_i && active_q && xe_ff_q && (steps_left_q == '0);

    // in multicolor mode a new pair is sampled on every other advance
    // the activating advance always samples the first pair
    assign mc_take = start || mc_ff_q;

    // a load landing on the activating tick counts as a load into an active sprite
    assign load_hit = load_valid_i && (load_i.id == MY_ID) && !active_q && !start;

    // sprite data register, shifted left by one bit on each advance
    always_ff @(posedge clk_dot4x) begin
        if (load_hit) begin
            data_q <= load_i.data;
        end else if (start || step) begin
            data_q <= {data_q[DATA_MSB-1:0], 1'b0};
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            active_q     <= 1'b0;
            xe_ff_q      <= 1'b1;
            mc_ff_q      <= 1'b1;
            steps_left_q <= '0;
            pixel_o      <= '0;
        end else begin
            if (start || step) begin
                if (cfg_i.mc) begin
                    // pair is held until the phase flip-flop comes round again
                    if (mc_take) begin
                        pixel_o <= data_q[DATA_MSB -: 2];
                    end
                    mc_ff_q <= !mc_take;
                end else begin
                    // single color bit maps onto the upper pixel bit only
                    pixel_o <= {data_q[DATA_MSB], 1'b0};
                    mc_ff_q <= 1'b1;
                end
                steps_left_q <= start ? FIRST_LEFT : steps_left_q - 1'b1;
                // expanded sprites skip the advance on the following tick
                xe_ff_q <= !cfg_i.xexp;
            end else if (finish) begin
                // last bit has had its full width, so the sprite goes idle
                active_q <= 1'b0;
                pixel_o  <= '0;
            end else if (pixel_tick_i && active_q) begin
                // second half of an expanded bit keeps the pixel as it is
                xe_ff_q <= 1'b1;
            end
            if (start) begin
                active_q <= 1'b1;
            end
        end
    end

    // an idle sprite never shows a pixel, including the tick it stops on
    idle_is_transparent: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        !active_q |-> (pixel_o == '0)
    ) else $error("sprite %0d shows a pixel while inactive", SPRITE_ID);

endmodule : sprite_shifter

`default_nettype wire

// File: hdl/sprite_priority.sv
`timescale 1ns/1ps
`default_nettype none

// picks the visible sprite with the lowest index and snapshots mmc and pri
// sampling waits one clock after the tick so the fresh shifter pixels are seen
module sprite_priority
    import sprite_pkg::*;
(
    input  wire             clk_dot4x,
    input  wire             rst,
    input  wire             pixel_tick_i,
    input  wire sprite_pix_vec_t pixels_i,
    input  wire sprite_cfg_vec_t cfg_i,
    input  wire sprite_mask_t    pri_i,
    output sprite_attr_t    attr_o
);

    logic                 tick_d_q;
    logic [SPRITE_ID_W:0] first_vis;
    sprite_mask_t         mc_mask;

    // scan from the top so the lowest visible index is written last
    always_comb begin
        first_vis = '0;
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            mc_mask[i] = cfg_i[i].mc;
            if (pixels_i[i] != '0) begin
                first_vis = {1'b1, SPRITE_ID_W'(i)};
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick_d_q <= 1'b0;
            attr_o   <= '0;
        end else begin
            tick_d_q <= pixel_tick_i;
            if (tick_d_q) begin
                attr_o.mmc           <= mc_mask;
                attr_o.pri           <= pri_i;
                attr_o.active_sprite <= first_vis;
            end
        end
    end

    valid_tracks_pixels: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        tick_d_q |=> (attr_o.active_sprite[SPRITE_ID_W] == ($past(pixels_i) != '0))
    ) else $error("active sprite valid flag disagrees with sprite pixels");

endmodule : sprite_priority

`default_nettype wire

// File: hdl/pixel_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

// fixed-depth pipeline that moves one item per pixel tick
// used for both the sprite pixels and the attributes that go with them
module pixel_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 6
) (
    input  wire   clk_dot4x,
    input  wire   rst,
    input  wire   pixel_tick_i,
    input  wire T data_i,
    output T      data_o
);

    // stage 0 takes the newest item, the last stage feeds the output
    T stage_q [DEPTH];

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            // flushing keeps stale sprites from showing right after reset
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (pixel_tick_i) begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // between ticks the output holds, so every consumer sees a stable item
    assign data_o = stage_q[DEPTH-1];

endmodule : pixel_delay_line

`default_nettype wire

// File: hdl/collision_detect.sv
`timescale 1ns/1ps
`default_nettype none

// sprite-to-sprite and sprite-to-background collision registers
// both work on the delayed pixels, so they match what reaches the screen
module collision_detect
    import sprite_pkg::*;
(
    input  wire             clk_dot4x,
    input  wire             rst,
    input  wire             pixel_tick_i,
    input  wire sprite_pix_vec_t pixels_i,
    input  wire sprite_mask_t    mmc_i,
    input  wire             is_background_pixel_i,
    input  wire             m2m_clr_i,
    input  wire             m2d_clr_i,
    input  wire             immc_clr_i,
    input  wire             imbc_clr_i,
    output sprite_mask_t    m2m_o,
    output sprite_mask_t    m2d_o,
    output logic            immc_o,
    output logic            imbc_o
);

    sprite_mask_t spr_coll;
    sprite_mask_t bg_coll;
    sprite_mask_t m2m_base;
    sprite_mask_t m2d_base;
    logic         m2m_hit;
    logic         m2d_hit;

    always_comb begin
        for (int i = 0; i < NUM_SPRITES; i++) begin
            // only the upper pixel bit takes part in sprite overlap
            spr_coll[i] = pixels_i[i][1];
            // visibility depends on whether this pixel was drawn in multicolor
            bg_coll[i] = (mmc_i[i] ? (pixels_i[i] != '0) : pixels_i[i][1])
                         && !is_background_pixel_i;
        end
        // clearing the lowest set bit leaves something only if two or more were set
        m2m_hit = pixel_tick_i && ((spr_coll & (spr_coll - 1'b1)) != '0);
        m2d_hit = pixel_tick_i && (bg_coll != '0);
        // a clear on the same clock empties the register before the new bits land
        m2m_base = m2m_clr_i ? '0 : m2m_o;
        m2d_base = m2d_clr_i ? '0 : m2d_o;
    end

    // an empty register is what arms the interrupt
    // the flag fires on the first collision after a clear and not again
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            m2m_o  <= '0;
            immc_o <= 1'b0;
        end else begin
            m2m_o <= m2m_base;
            if (m2m_clr_i || immc_clr_i) begin
                immc_o <= 1'b0;
            end
            // a collision on the clearing clock still gets recorded
            if (m2m_hit) begin
                m2m_o <= m2m_base | spr_coll;
                if (m2m_base == '0) begin
                    immc_o <= 1'b1;
                end
            end
        end
    end

    // same scheme for sprites drawn over foreground graphics
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            m2d_o  <= '0;
            imbc_o <= 1'b0;
        end else begin
            m2d_o <= m2d_base;
            if (m2d_clr_i || imbc_clr_i) begin
                imbc_o <= 1'b0;
            end
            if (m2d_hit) begin
                m2d_o <= m2d_base | bg_coll;
                if (m2d_base == '0) begin
                    imbc_o <= 1'b1;
                end
            end
        end
    end

    immc_needs_m2m: assert property (
        @(posedge clk_dot4x) disable iff (rst)
        immc_o |-> (m2m_o != '0)
    ) else $error("immc raised with an empty m2m register");

endmodule : collision_detect

`default_nettype wire

// File: hdl/sprite_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// sprite pixel path
// shifters feed the priority stage, both are delayed to line up with graphics,
// and collisions are judged on the delayed pixels
module sprite_sequencer
    import sprite_pkg::*;
#(
    parameter int DELAY_DEPTH = 6
) (
    input  wire              clk_dot4x,
    input  wire              rst,
    input  wire sprite_cfg_vec_t cfg_i,
    input  wire sprite_mask_t    pri_i,
    input  wire [XPOS_W-1:0] xpos_i,
    input  wire              pixel_tick_i,
    input  wire              load_valid_i,
    input  wire sprite_load_t    load_i,
    input  wire              is_background_pixel_i,
    input  wire              m2m_clr_i,
    input  wire              m2d_clr_i,
    input  wire              immc_clr_i,
    input  wire              imbc_clr_i,
    output sprite_pix_vec_t  pixels_o,
    output sprite_attr_t     attr_o,
    output sprite_mask_t     m2m_o,
    output sprite_mask_t     m2d_o,
    output logic             immc_o,
    output logic             imbc_o
);

    // undelayed pixels and the attributes computed from them
    sprite_pix_vec_t pix_raw;
    sprite_attr_t    attr_raw;

    // every shifter sees the shared load bus and picks out its own index
    for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_sprite
        sprite_shifter #(
            .SPRITE_ID (g)
        ) u_sprite_shifter (
            .clk_dot4x    (clk_dot4x),
            .rst          (rst),
            .pixel_tick_i (pixel_tick_i),
            .xpos_i       (xpos_i),
            .cfg_i        (cfg_i[g]),
            .load_valid_i (load_valid_i),
            .load_i       (load_i),
            .pixel_o      (pix_raw[g])
        );
    end

    sprite_priority u_sprite_priority (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .pixel_tick_i (pixel_tick_i),
        .pixels_i     (pix_raw),
        .cfg_i        (cfg_i),
        .pri_i        (pri_i),
        .attr_o       (attr_raw)
    );

    // both pipelines have the same depth so each pixel keeps its attributes
    pixel_delay_line #(
        .T     (sprite_pix_vec_t),
        .DEPTH (DELAY_DEPTH)
    ) u_pix_delay (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .pixel_tick_i (pixel_tick_i),
        .data_i       (pix_raw),
        .data_o       (pixels_o)
    );

    pixel_delay_line #(
        .T     (sprite_attr_t),
        .DEPTH (DELAY_DEPTH)
    ) u_attr_delay (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .pixel_tick_i (pixel_tick_i),
        .data_i       (attr_raw),
        .data_o       (attr_o)
    );

    // background flag belongs to the delayed pixel presented on this tick
    collision_detect u_collision_detect (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .pixel_tick_i          (pixel_tick_i),
        .pixels_i              (pixels_o),
        .mmc_i                 (attr_o.mmc),
        .is_background_pixel_i (is_background_pixel_i),
        .m2m_clr_i             (m2m_clr_i),
        .m2d_clr_i             (m2d_clr_i),
        .immc_clr_i            (immc_clr_i),
        .imbc_clr_i            (imbc_clr_i),
        .m2m_o                 (m2m_o),
        .m2d_o                 (m2d_o),
        .immc_o                (immc_o),
        .imbc_o                (imbc_o)
    );

endmodule : sprite_sequencer

`default_nettype wire

// File: bench/sprite_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_tb
    import sprite_pkg::*;
();

    localparam int DEPTH = 6;
    // tick counts of all runs together plus a reset allowance per run
    localparam int TOTAL_TICKS = 40 + 64 + 40 + 64 + 70 + 60 + 44 + 70;
    localparam int WATCHDOG_CLKS = TOTAL_TICKS * 4 + 9 * 8 + 500;
    localparam int NO_START = -10000;

    logic            clk_dot4x = 1'b0;
    logic            rst;
    sprite_cfg_vec_t cfg_i;
    sprite_mask_t    pri_i;
    logic [XPOS_W-1:0] xpos_i;
    logic            pixel_tick_i;
    logic            load_valid_i;
    sprite_load_t    load_i;
    logic            is_background_pixel_i;
    logic            m2m_clr_i;
    logic            m2d_clr_i;
    logic            immc_clr_i;
    logic            imbc_clr_i;
    sprite_pix_vec_t pixels_o;
    sprite_attr_t    attr_o;
    sprite_mask_t    m2m_o;
    sprite_mask_t    m2d_o;
    logic            immc_o;
    logic            imbc_o;

    // per-sprite setup of the running test and of a second pass after a reload
    logic [SPRITE_DATA_W-1:0] spr_data0 [NUM_SPRITES];
    logic [SPRITE_DATA_W-1:0] spr_data1 [NUM_SPRITES];
    int                       spr_start0 [NUM_SPRITES];
    int                       spr_start1 [NUM_SPRITES];
    logic [XPOS_W-1:0]        spr_xpos [NUM_SPRITES];
    sprite_mask_t             spr_disp;
    sprite_mask_t             spr_xexp;
    sprite_mask_t             spr_mc;
    sprite_mask_t             pri_hist [256];
    logic                     bg_hist [256];

    int next_n;
    int cur_n;
    logic tick_seen;
    int err_count = 0;
    int check_count = 0;
    int failed_tests = 0;
    int test_num = 0;
    int test_errs_before;
    string test_name;

    // expected collision state is advanced on every clock
    sprite_mask_t exp_m2m;
    sprite_mask_t exp_m2d;
    logic         exp_immc;
    logic         exp_imbc;

    sprite_sequencer #(
        .DELAY_DEPTH (DEPTH)
    ) u_sprite_sequencer (
        .clk_dot4x             (clk_dot4x),
        .rst                   (rst),
        .cfg_i                 (cfg_i),
        .pri_i                 (pri_i),
        .xpos_i                (xpos_i),
        .pixel_tick_i          (pixel_tick_i),
        .load_valid_i          (load_valid_i),
        .load_i                (load_i),
        .is_background_pixel_i (is_background_pixel_i),
        .m2m_clr_i             (m2m_clr_i),
        .m2d_clr_i             (m2d_clr_i),
        .immc_clr_i            (immc_clr_i),
        .imbc_clr_i            (imbc_clr_i),
        .pixels_o              (pixels_o),
        .attr_o                (attr_o),
        .m2m_o                 (m2m_o),
        .m2d_o                 (m2d_o),
        .immc_o                (immc_o),
        .imbc_o                (imbc_o)
    );

    always #10 clk_dot4x = ~clk_dot4x;

    // pixel of one sprite pass where rel counts ticks from the activating tick
    function automatic sprite_pix_t pix_at(logic [SPRITE_DATA_W-1:0] data, logic xexp,
                                           logic mc, int rel);
        int len;
        int unit;
        int b;
        len = xexp ? 2 * SPRITE_DATA_W : SPRITE_DATA_W;
        if (rel < 0 || rel >= len) begin
            return '0;
        end
        unit = xexp ? rel / 2 : rel;
        if (mc) begin
            // pairs go out msb first and each covers two data bit slots
            b = SPRITE_DATA_W - 1 - 2 * (unit / 2);
            return data[b -: 2];
        end
        return {data[SPRITE_DATA_W-1-unit], 1'b0};
    endfunction

    // undelayed shifter outputs right after tick m
    function automatic sprite_pix_vec_t raw_vec(int m);
        sprite_pix_vec_t v;
        v = '0;
        if (m < 0) begin
            return v;
        end
        for (int s = 0; s < NUM_SPRITES; s++) begin
            v[s] = pix_at(spr_data0[s], spr_xexp[s], spr_mc[s], m - spr_start0[s])
                 | pix_at(spr_data1[s], spr_xexp[s], spr_mc[s], m - spr_start1[s]);
        end
        return v;
    endfunction

    // attributes that belong to the pixels of tick m
    function automatic sprite_attr_t attr_ref(int m);
        sprite_attr_t    a;
        sprite_pix_vec_t v;
        logic            found;
        a = '0;
        found = 1'b0;
        if (m < 0) begin
            return a;
        end
        v = raw_vec(m);
        a.mmc = spr_mc;
        a.pri = pri_hist[m];
        for (int s = 0; s < NUM_SPRITES; s++) begin
            if (!found && v[s] != '0) begin
                found = 1'b1;
                a.active_sprite = {1'b1, SPRITE_ID_W'(s)};
            end
        end
        return a;
    endfunction

    task automatic check_pix_vec(string name, sprite_pix_vec_t got, sprite_pix_vec_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s tick %0d: got %h expected %h", name, cur_n, got, exp);
        end
    endtask

    task automatic check_attr(string name, sprite_attr_t got, sprite_attr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s tick %0d: got %h expected %h", name, cur_n, got, exp);
        end
    endtask

    task automatic check_mask(string name, sprite_mask_t got, sprite_mask_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s tick %0d: got %h expected %h", name, cur_n, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED %s tick %0d: got %h expected %h", name, cur_n, got, exp);
        end
    endtask

    always @(posedge clk_dot4x) begin
        tick_seen <= pixel_tick_i && !rst;
    end

    // the collision reference judges the delayed pixels seen just before this edge
    always @(posedge clk_dot4x) begin : collision_model
        sprite_pix_vec_t dp;
        sprite_mask_t    mm;
        sprite_mask_t    sc;
        sprite_mask_t    bc;
        sprite_mask_t    base;
        if (rst) begin
            exp_m2m = '0;
            exp_m2d = '0;
            exp_immc = 1'b0;
            exp_imbc = 1'b0;
        end else begin
            dp = raw_vec(cur_n - DEPTH - 1);
            mm = (cur_n - DEPTH - 1 < 0) ? '0 : spr_mc;
            for (int i = 0; i < NUM_SPRITES; i++) begin
                sc[i] = dp[i][1];
                bc[i] = (mm[i] ? (dp[i] != '0) : dp[i][1]) && !is_background_pixel_i;
            end
            base = m2m_clr_i ? '0 : exp_m2m;
            if (m2m_clr_i || immc_clr_i) begin
                exp_immc = 1'b0;
            end
            if (pixel_tick_i && $countones(sc) >= 2) begin
                if (base == '0) begin
                    exp_immc = 1'b1;
                end
                exp_m2m = base | sc;
            end else begin
                exp_m2m = base;
            end
            base = m2d_clr_i ? '0 : exp_m2d;
            if (m2d_clr_i || imbc_clr_i) begin
                exp_imbc = 1'b0;
            end
            if (pixel_tick_i && bc != '0) begin
                if (base == '0) begin
                    exp_imbc = 1'b1;
                end
                exp_m2d = base | bc;
            end else begin
                exp_m2d = base;
            end
        end
    end

    // compare on the falling edge after every tick, when all outputs have settled
    always @(negedge clk_dot4x) begin
        if (tick_seen) begin
            check_pix_vec("pixels_o", pixels_o, raw_vec(cur_n - DEPTH));
            check_attr("attr_o", attr_o, attr_ref(cur_n - DEPTH));
            check_mask("m2m_o", m2m_o, exp_m2m);
            check_mask("m2d_o", m2d_o, exp_m2d);
            check_flag("immc_o", immc_o, exp_immc);
            check_flag("imbc_o", imbc_o, exp_imbc);
        end
    end

    initial begin
        #(WATCHDOG_CLKS * 20);
        $display("watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic apply_cfg();
        for (int s = 0; s < NUM_SPRITES; s++) begin
            cfg_i[s].xpos = spr_xpos[s];
            cfg_i[s].display = spr_disp[s];
            cfg_i[s].xexp = spr_xexp[s];
            cfg_i[s].mc = spr_mc[s];
        end
    endtask

    // a new run starts from reset with every sprite off and the beam at x 0
    task automatic reset_dut();
        rst = 1'b1;
        pixel_tick_i = 1'b0;
        load_valid_i = 1'b0;
        {m2m_clr_i, m2d_clr_i, immc_clr_i, imbc_clr_i} = '0;
        next_n = 0;
        cur_n = 0;
        spr_disp = '0;
        spr_xexp = '0;
        spr_mc = '0;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            spr_data0[s] = '0;
            spr_data1[s] = '0;
            spr_start0[s] = NO_START;
            spr_start1[s] = NO_START;
            spr_xpos[s] = '1;
        end
        for (int n = 0; n < 256; n++) begin
            pri_hist[n] = '0;
            bg_hist[n] = 1'b1;
        end
        apply_cfg();
        repeat (3) @(negedge clk_dot4x);
        rst = 1'b0;
    endtask

    task automatic load_now(int id, logic [SPRITE_DATA_W-1:0] data);
        load_valid_i = 1'b1;
        load_i.id = SPRITE_ID_W'(id);
        load_i.data = data;
        @(negedge clk_dot4x);
        load_valid_i = 1'b0;
    endtask

    task automatic setup_sprite(int s, int x, logic [SPRITE_DATA_W-1:0] d, logic xe, logic mc);
        spr_xpos[s] = XPOS_W'(x);
        spr_disp[s] = 1'b1;
        spr_xexp[s] = xe;
        spr_mc[s] = mc;
        spr_data0[s] = d;
        spr_start0[s] = x;
        apply_cfg();
        load_now(s, d);
    endtask

    // one pixel tick lasts four clocks
    // strobes set after a tick last for one clock
    task automatic run_ticks(int count);
        repeat (count) begin
            @(negedge clk_dot4x);
            load_valid_i = 1'b0;
            {m2m_clr_i, m2d_clr_i, immc_clr_i, imbc_clr_i} = '0;
            pixel_tick_i = 1'b1;
            xpos_i = XPOS_W'(next_n);
            pri_i = pri_hist[next_n];
            is_background_pixel_i = bg_hist[next_n];
            cur_n = next_n;
            next_n++;
            @(negedge clk_dot4x);
            pixel_tick_i = 1'b0;
            @(negedge clk_dot4x);
            @(negedge clk_dot4x);
        end
    endtask

    task automatic begin_test(string name);
        test_num++;
        test_errs_before = err_count;
        test_name = name;
    endtask

    task automatic end_test();
        if (err_count == test_errs_before) begin
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d mismatches", test_num, test_name,
                     err_count - test_errs_before);
        end
    endtask

    initial begin
        rst = 1'b1;
        cfg_i = '0;
        pri_i = '0;
        xpos_i = '0;
        pixel_tick_i = 1'b0;
        load_valid_i = 1'b0;
        load_i = '0;
        is_background_pixel_i = 1'b1;
        {m2m_clr_i, m2d_clr_i, immc_clr_i, imbc_clr_i} = '0;
        void'($urandom(81));

        begin_test("single color stream");
        reset_dut();
        setup_sprite(0, 3, SPRITE_DATA_W'($urandom), 1'b0, 1'b0);
        run_ticks(40);
        reset_dut();
        setup_sprite(6, 5, SPRITE_DATA_W'($urandom), 1'b1, 1'b0);
        run_ticks(64);
        end_test();

        begin_test("multicolor pairs");
        reset_dut();
        setup_sprite(2, 2, SPRITE_DATA_W'($urandom), 1'b0, 1'b1);
        run_ticks(40);
        reset_dut();
        setup_sprite(7, 4, SPRITE_DATA_W'($urandom), 1'b1, 1'b1);
        run_ticks(64);
        end_test();

        begin_test("priority and attributes");
        reset_dut();
        for (int n = 0; n < 256; n++) begin
            pri_hist[n] = sprite_mask_t'($urandom);
            bg_hist[n] = 1'($urandom);
        end
        setup_sprite(1, 3, SPRITE_DATA_W'($urandom), 1'b0, 1'b0);
        setup_sprite(3, 5, SPRITE_DATA_W'($urandom), 1'b0, 1'b1);
        setup_sprite(5, 7, SPRITE_DATA_W'($urandom), 1'b1, 1'b0);
        run_ticks(70);
        end_test();

        begin_test("sprite to sprite collision");
        reset_dut();
        setup_sprite(0, 4, 24'hff0000, 1'b0, 1'b0);
        setup_sprite(1, 4, 24'hff0000, 1'b0, 1'b0);
        run_ticks(25);
        m2m_clr_i = 1'b1;
        immc_clr_i = 1'b1;
        run_ticks(6);
        // both sprites shifted out their data, so they need a reload
        load_valid_i = 1'b1;
        load_i = {3'd0, 24'hff0000};
        run_ticks(1);
        load_valid_i = 1'b1;
        load_i = {3'd1, 24'hff0000};
        spr_data1[0] = 24'hff0000;
        spr_data1[1] = 24'hff0000;
        spr_xpos[0] = XPOS_W'(40);
        spr_xpos[1] = XPOS_W'(40);
        spr_start1[0] = 40;
        spr_start1[1] = 40;
        apply_cfg();
        run_ticks(28);
        end_test();

        begin_test("sprite to background collision");
        reset_dut();
        for (int n = 20; n < 26; n++) begin
            bg_hist[n] = 1'b0;
        end
        setup_sprite(4, 4, 24'hffffff, 1'b0, 1'b0);
        run_ticks(31);
        m2d_clr_i = 1'b1;
        imbc_clr_i = 1'b1;
        run_ticks(13);
        end_test();

        begin_test("load while active");
        reset_dut();
        setup_sprite(0, 4, SPRITE_DATA_W'($urandom), 1'b0, 1'b0);
        run_ticks(11);
        // sprite 0 is active here, so this load must not land
        load_valid_i = 1'b1;
        load_i = {3'd0, 24'h5a5a5a};
        run_ticks(19);
        load_valid_i = 1'b1;
        load_i = {3'd0, 24'hc3a517};
        spr_data1[0] = 24'hc3a517;
        spr_xpos[0] = XPOS_W'(40);
        spr_start1[0] = 40;
        apply_cfg();
        run_ticks(40);
        end_test();

        $display("tests %0d, failing tests %0d, checks %0d, mismatches %0d",
                 test_num, failed_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : sprite_tb

`default_nettype wire

// File: sources.f
hdl/sprite_pkg.sv
hdl/sprite_shifter.sv
hdl/sprite_priority.sv
hdl/pixel_delay_line.sv
hdl/collision_detect.sv
hdl/sprite_sequencer.sv
bench/sprite_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the sprite testbench with Verilator, run it, and judge the run by its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sprite_tb -f sources.f -o sprite_sim \
    && ./obj_dir/sprite_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && exit 0 \
    || exit 1
